// ==== hw/rv_consts.svh ====
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// datapath and storage sizes
`define RV_XLEN        32
`define RV_NREG        32
`define RV_IMEM_DEPTH  64
`define RV_RESET_PC    32'h0000_0000

// major opcode field, instr[6:0]
`define RV_OP_OP       7'b0110011
`define RV_OP_OPIMM    7'b0010011
`define RV_OP_LUI      7'b0110111
`define RV_OP_LOAD     7'b0000011
`define RV_OP_STORE    7'b0100011
`define RV_OP_BRANCH   7'b1100011

`endif

// ==== hw/rv_pkg.sv ====
`include "rv_consts.svh"

package rv_pkg;

  typedef logic [`RV_XLEN-1:0]          word_t;
  typedef logic [$clog2(`RV_NREG)-1:0]  reg_idx_t;

  typedef enum logic [2:0]
  {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_PASSB
  } alu_op_t;

  //////////////////////////////////////////////////
  // stage boundaries, valid low marks a bubble
  //////////////////////////////////////////////////

  typedef struct packed
  {
    logic   valid;
    word_t  pc;
    word_t  instr;
  } if_id_t;

  typedef struct packed
  {
    logic      valid;
    word_t     pc;
    reg_idx_t  rs1;
    reg_idx_t  rs2;
    reg_idx_t  rd;
    word_t     rs1_val;
    word_t     rs2_val;
    word_t     imm;
    alu_op_t   alu_op;
    logic      use_imm;
    logic      reg_write;
    logic      mem_read;
    logic      mem_write;
    logic      is_branch;
    logic      branch_ne;
  } id_ex_t;

  typedef struct packed
  {
    logic      valid;
    reg_idx_t  rd;
    word_t     alu_res;
    word_t     store_data;
    logic      reg_write;
    logic      mem_read;
    logic      mem_write;
  } ex_mem_t;

  typedef struct packed
  {
    logic      valid;
    reg_idx_t  rd;
    word_t     result;
    logic      reg_write;
  } mem_wb_t;

  // data memory request packet
  typedef struct packed
  {
    logic   we;
    word_t  addr;
    word_t  wdata;
  } dmem_req_t;

endpackage

// ==== hw/pipe_reg.sv ====
`timescale 1ns/100ps

module pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic      clk,
  input  logic      rst,
  input  logic      hold,
  input  logic      flush,
  input  payload_t  d,
  output payload_t  q
);

  // cleared payload is a bubble
  always_ff @(posedge clk)
  begin
    if (rst || flush)
      q <= '0;
    else if (!hold)
      q <= d;
  end

  // stall and flush network in the top level must never overlap
  assert property (@(posedge clk) disable iff (rst) !(hold && flush))
    else $error("pipe_reg: hold and flush both high");

endmodule

// ==== hw/fetch_stage.sv ====
`timescale 1ns/100ps
`include "rv_consts.svh"

module fetch_stage (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               stall,
  input  logic                               redirect,
  input  logic [`RV_XLEN-1:0]                redirect_pc,
  input  logic                               prog_we,
  input  logic [$clog2(`RV_IMEM_DEPTH)-1:0]  prog_addr,
  input  logic [`RV_XLEN-1:0]                prog_data,
  output rv_pkg::if_id_t                     if_out
);

  import rv_pkg::*;

  localparam int IMEM_AW = $clog2(`RV_IMEM_DEPTH);

  word_t pc;
  word_t imem [0:`RV_IMEM_DEPTH-1];

  // program port, usable while the core sits in reset
  always_ff @(posedge clk)
  begin
    if (prog_we)
      imem[prog_addr] <= prog_data;
  end

  // redirect wins over a stall
  always_ff @(posedge clk)
  begin
    if (rst)
      pc <= `RV_RESET_PC;
    else if (redirect)
      pc <= redirect_pc;
    else if (!stall)
      pc <= pc + 32'd4;
  end

  always_comb
  begin
    // outside the memory the fetch is a bubble
    if_out.valid = (pc[`RV_XLEN-1:IMEM_AW+2] == '0);
    if_out.pc    = pc;
    if_out.instr = imem[pc[IMEM_AW+1:2]];
  end

endmodule

// ==== hw/regfile.sv ====
`timescale 1ns/100ps
`include "rv_consts.svh"

module regfile (
  input  logic              clk,
  input  logic              rst,
  input  rv_pkg::reg_idx_t  rs1_addr,
  input  rv_pkg::reg_idx_t  rs2_addr,
  output rv_pkg::word_t     rs1_val,
  output rv_pkg::word_t     rs2_val,
  input  rv_pkg::mem_wb_t   wb,
  input  rv_pkg::reg_idx_t  dbg_addr,
  output rv_pkg::word_t     dbg_data
);

  import rv_pkg::*;

  word_t regs [0:`RV_NREG-1];
  logic  we;

  // x0 is never stored
  assign we = wb.valid && wb.reg_write && (wb.rd != '0);

  always_ff @(posedge clk)
  begin
    if (we)
      regs[wb.rd] <= wb.result;
  end

  // same-cycle write shows through, so writeback needs no extra path
  function automatic word_t read_port(input reg_idx_t addr, input word_t stored,
                                      input logic wr_en, input mem_wb_t wr);
    word_t val;
    if (addr == '0)
      val = '0;
    else if (wr_en && wr.rd == addr)
      val = wr.result;
    else
      val = stored;
    return val;
  endfunction

  assign rs1_val = read_port(rs1_addr, regs[rs1_addr], we, wb);
  assign rs2_val = read_port(rs2_addr, regs[rs2_addr], we, wb);

  always_ff @(posedge clk)
  begin
    if (rst)
      dbg_data <= '0;
    else
      dbg_data <= read_port(dbg_addr, regs[dbg_addr], we, wb);
  end

endmodule

// ==== hw/decode_stage.sv ====
`timescale 1ns/100ps
`include "rv_consts.svh"

module decode_stage (
  input  rv_pkg::if_id_t    if_in,
  input  rv_pkg::id_ex_t    ex_in,
  output rv_pkg::reg_idx_t  rs1_addr,
  output rv_pkg::reg_idx_t  rs2_addr,
  input  rv_pkg::word_t     rs1_val,
  input  rv_pkg::word_t     rs2_val,
  output rv_pkg::id_ex_t    id_out,
  output logic              hazard
);

  import rv_pkg::*;

  word_t       instr;
  logic [6:0]  opcode;
  logic [2:0]  funct3;
  word_t       imm_i, imm_s, imm_b, imm_u;
  logic        legal;
  logic        use_rs1;
  logic        use_rs2;

  assign instr    = if_in.instr;
  assign opcode   = instr[6:0];
  assign funct3   = instr[14:12];
  assign rs1_addr = instr[19:15];
  assign rs2_addr = instr[24:20];

  // sign-extended immediates per format
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};

  always_comb
  begin
    legal   = 1'b0;
    use_rs1 = 1'b0;
    use_rs2 = 1'b0;
    id_out  = '0;
    id_out.alu_op = ALU_ADD;
    case (opcode)
      `RV_OP_OP:
      begin
        legal   = 1'b1;
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        id_out.reg_write = 1'b1;
        case (funct3)
          3'b000:  id_out.alu_op = instr[30] ? ALU_SUB : ALU_ADD;
          3'b010:  id_out.alu_op = ALU_SLT;
          3'b100:  id_out.alu_op = ALU_XOR;
          3'b110:  id_out.alu_op = ALU_OR;
          3'b111:  id_out.alu_op = ALU_AND;
          default: legal = 1'b0;
        endcase
      end
      `RV_OP_OPIMM:
      begin
        legal   = 1'b1;
        use_rs1 = 1'b1;
        id_out.use_imm   = 1'b1;
        id_out.reg_write = 1'b1;
        id_out.imm       = imm_i;
        case (funct3)
          3'b000:  id_out.alu_op = ALU_ADD;
          3'b100:  id_out.alu_op = ALU_XOR;
          3'b110:  id_out.alu_op = ALU_OR;
          3'b111:  id_out.alu_op = ALU_AND;
          default: legal = 1'b0;
        endcase
      end
      `RV_OP_LUI:
      begin
        legal = 1'b1;
        id_out.use_imm   = 1'b1;
        id_out.reg_write = 1'b1;
        id_out.imm       = imm_u;
        id_out.alu_op    = ALU_PASSB;
      end
      `RV_OP_LOAD:
      begin
        // word loads only
        legal   = (funct3 == 3'b010);
        use_rs1 = 1'b1;
        id_out.use_imm   = 1'b1;
        id_out.reg_write = 1'b1;
        id_out.mem_read  = 1'b1;
        id_out.imm       = imm_i;
      end
      `RV_OP_STORE:
      begin
        legal   = (funct3 == 3'b010);
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        id_out.use_imm   = 1'b1;
        id_out.mem_write = 1'b1;
        id_out.imm       = imm_s;
      end
      `RV_OP_BRANCH:
      begin
        // beq and bne
        legal   = (funct3[2:1] == 2'b00);
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        id_out.is_branch = 1'b1;
        id_out.branch_ne = funct3[0];
        id_out.imm       = imm_b;
      end
      default:
      begin
        legal = 1'b0;
      end
    endcase
    id_out.valid   = if_in.valid && legal;
    id_out.pc      = if_in.pc;
    id_out.rs1     = use_rs1 ? rs1_addr : '0;
    id_out.rs2     = use_rs2 ? rs2_addr : '0;
    id_out.rd      = instr[11:7];
    id_out.rs1_val = rs1_val;
    id_out.rs2_val = rs2_val;
  end

  // load in execute feeding this instruction costs one bubble
  assign hazard = id_out.valid && ex_in.valid && ex_in.mem_read && (ex_in.rd != '0) &&
                  ((use_rs1 && ex_in.rd == rs1_addr) || (use_rs2 && ex_in.rd == rs2_addr));

endmodule

// ==== hw/execute_stage.sv ====
`timescale 1ns/100ps

module execute_stage (
  input  logic             clk,
  input  logic             rst,
  input  logic             stall,
  input  rv_pkg::id_ex_t   ex_in,
  input  rv_pkg::ex_mem_t  fwd_mem,
  input  rv_pkg::mem_wb_t  fwd_wb,
  output rv_pkg::ex_mem_t  ex_out,
  output logic             redirect,
  output rv_pkg::word_t    redirect_pc,
  output logic             halted
);

  import rv_pkg::*;

  word_t op_a;
  word_t rs2_fwd;
  word_t op_b;
  word_t alu_res;
  logic  taken;

  //////////////////////////////////////////////////
  // forwarding
  //////////////////////////////////////////////////

  // memory stage first, then writeback; loads in memory are covered by the bubble
  function automatic word_t forward(input reg_idx_t src, input word_t reg_val,
                                    input ex_mem_t m, input mem_wb_t w);
    word_t val;
    if (src == '0)
      val = reg_val;
    else if (m.valid && m.reg_write && !m.mem_read && m.rd == src)
      val = m.alu_res;
    else if (w.valid && w.reg_write && w.rd == src)
      val = w.result;
    else
      val = reg_val;
    return val;
  endfunction

  assign op_a    = forward(ex_in.rs1, ex_in.rs1_val, fwd_mem, fwd_wb);
  assign rs2_fwd = forward(ex_in.rs2, ex_in.rs2_val, fwd_mem, fwd_wb);
  assign op_b    = ex_in.use_imm ? ex_in.imm : rs2_fwd;

  always_comb
  begin
    alu_res = '0;
    case (ex_in.alu_op)
      ALU_ADD:   alu_res = op_a + op_b;
      ALU_SUB:   alu_res = op_a - op_b;
      ALU_AND:   alu_res = op_a & op_b;
      ALU_OR:    alu_res = op_a | op_b;
      ALU_XOR:   alu_res = op_a ^ op_b;
      ALU_SLT:   alu_res[0] = ($signed(op_a) < $signed(op_b));
      ALU_PASSB: alu_res = op_b;
      default:   alu_res = '0;
    endcase
  end

  //////////////////////////////////////////////////
  // branch resolve
  //////////////////////////////////////////////////

  assign taken       = ex_in.valid && ex_in.is_branch && ((op_a == rs2_fwd) ^ ex_in.branch_ne);
  assign redirect_pc = ex_in.pc + ex_in.imm;
  // held until memory lets the pipe move
  assign redirect    = taken && !stall;

  // a taken branch onto itself parks the core
  always_ff @(posedge clk)
  begin
    if (rst)
      halted <= 1'b0;
    else if (redirect && redirect_pc == ex_in.pc)
      halted <= 1'b1;
  end

  always_comb
  begin
    ex_out.valid      = ex_in.valid;
    ex_out.rd         = ex_in.rd;
    ex_out.alu_res    = alu_res;
    ex_out.store_data = rs2_fwd;
    ex_out.reg_write  = ex_in.reg_write;
    ex_out.mem_read   = ex_in.mem_read;
    ex_out.mem_write  = ex_in.mem_write;
  end

endmodule

// ==== hw/memory_stage.sv ====
`timescale 1ns/100ps

module memory_stage (
  input  logic               clk,
  input  logic               rst,
  input  rv_pkg::ex_mem_t    mem_in,
  output logic               dmem_req,
  output rv_pkg::dmem_req_t  dmem_pkt,
  input  logic               dmem_ack,
  input  rv_pkg::word_t      dmem_rdata,
  output logic               mem_busy,
  output rv_pkg::mem_wb_t    wb_out
);

  import rv_pkg::*;

  typedef enum logic [1:0] {IDLE, WAIT_ACK, WAIT_DROP} hs_state_t;

  hs_state_t state;
  logic      mem_op;
  logic      done;
  logic      start;
  word_t     load_data;

  assign mem_op = mem_in.valid && (mem_in.mem_read || mem_in.mem_write);
  // done marks the one cycle the finished access leaves the stage
  assign start    = (state == IDLE) && mem_op && !done;
  assign mem_busy = mem_op && !done;

  //////////////////////////////////////////////////
  // four-phase handshake
  //////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= IDLE;
      done  <= 1'b0;
    end
    else
    begin
      case (state)
        IDLE:
        begin
          done <= 1'b0;
          if (start)
            state <= WAIT_ACK;
        end
        WAIT_ACK:
        begin
          if (dmem_ack)
            state <= WAIT_DROP;
        end
        WAIT_DROP:
        begin
          if (!dmem_ack)
          begin
            state <= IDLE;
            done  <= 1'b1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // rdata is only good while ack is up
  always_ff @(posedge clk)
  begin
    if (state == WAIT_ACK && dmem_ack)
      load_data <= dmem_rdata;
  end

  assign dmem_req       = (state == WAIT_ACK);
  assign dmem_pkt.we    = mem_in.mem_write;
  assign dmem_pkt.addr  = mem_in.alu_res;
  assign dmem_pkt.wdata = mem_in.store_data;

  always_comb
  begin
    wb_out.valid     = mem_in.valid;
    wb_out.rd        = mem_in.rd;
    wb_out.reg_write = mem_in.reg_write;
    wb_out.result    = mem_in.mem_read ? load_data : mem_in.alu_res;
  end

  assert property (@(posedge clk) disable iff (rst)
    dmem_req |=> !dmem_req || $stable(dmem_pkt))
    else $error("memory_stage: dmem_pkt moved under req");

  assert property (@(posedge clk) disable iff (rst)
    $rose(dmem_req) |-> !$past(dmem_ack))
    else $error("memory_stage: req raised while ack high");

endmodule

// ==== hw/rv_core.sv ====
`timescale 1ns/100ps
`include "rv_consts.svh"

module rv_core (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               prog_we,
  input  logic [$clog2(`RV_IMEM_DEPTH)-1:0]  prog_addr,
  input  rv_pkg::word_t                      prog_data,
  input  rv_pkg::reg_idx_t                   dbg_addr,
  output rv_pkg::word_t                      dbg_data,
  output logic                               dmem_req,
  output rv_pkg::dmem_req_t                  dmem_pkt,
  input  logic                               dmem_ack,
  input  rv_pkg::word_t                      dmem_rdata,
  output logic                               halted
);

  import rv_pkg::*;

  if_id_t   if_d, if_q;
  id_ex_t   id_d, id_q;
  ex_mem_t  ex_d, ex_q;
  mem_wb_t  mem_d, mem_q;
  reg_idx_t rs1_addr, rs2_addr;
  word_t    rs1_val, rs2_val;
  word_t    redirect_pc;
  logic     hazard, redirect, mem_busy;
  logic     front_stall, id_ex_flush;

  //////////////////////////////////////////////////
  // stall and flush network
  //////////////////////////////////////////////////

  // redirect is already quiet while memory is busy
  assign front_stall = mem_busy || hazard;
  assign id_ex_flush = (hazard || redirect) && !mem_busy;

  fetch_stage u_fetch (
    .clk(clk), .rst(rst), .stall(front_stall),
    .redirect(redirect), .redirect_pc(redirect_pc),
    .prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
    .if_out(if_d)
  );

  pipe_reg #(.payload_t(if_id_t)) u_if_id (
    .clk(clk), .rst(rst), .hold(front_stall), .flush(redirect), .d(if_d), .q(if_q)
  );

  regfile u_regfile (
    .clk(clk), .rst(rst),
    .rs1_addr(rs1_addr), .rs2_addr(rs2_addr), .rs1_val(rs1_val), .rs2_val(rs2_val),
    .wb(mem_q), .dbg_addr(dbg_addr), .dbg_data(dbg_data)
  );

  decode_stage u_decode (
    .if_in(if_q), .ex_in(id_q),
    .rs1_addr(rs1_addr), .rs2_addr(rs2_addr), .rs1_val(rs1_val), .rs2_val(rs2_val),
    .id_out(id_d), .hazard(hazard)
  );

  pipe_reg #(.payload_t(id_ex_t)) u_id_ex (
    .clk(clk), .rst(rst), .hold(mem_busy), .flush(id_ex_flush), .d(id_d), .q(id_q)
  );

  execute_stage u_execute (
    .clk(clk), .rst(rst), .stall(mem_busy),
    .ex_in(id_q), .fwd_mem(ex_q), .fwd_wb(mem_q), .ex_out(ex_d),
    .redirect(redirect), .redirect_pc(redirect_pc), .halted(halted)
  );

  pipe_reg #(.payload_t(ex_mem_t)) u_ex_mem (
    .clk(clk), .rst(rst), .hold(mem_busy), .flush(1'b0), .d(ex_d), .q(ex_q)
  );

  memory_stage u_memory (
    .clk(clk), .rst(rst), .mem_in(ex_q),
    .dmem_req(dmem_req), .dmem_pkt(dmem_pkt), .dmem_ack(dmem_ack), .dmem_rdata(dmem_rdata),
    .mem_busy(mem_busy), .wb_out(mem_d)
  );

  // last register feeds the register file write port
  pipe_reg #(.payload_t(mem_wb_t)) u_mem_wb (
    .clk(clk), .rst(rst), .hold(mem_busy), .flush(1'b0), .d(mem_d), .q(mem_q)
  );

endmodule

// ==== tests/rv_core_tb.sv ====
`timescale 1ns/100ps
`include "rv_consts.svh"

module rv_core_tb;

  import rv_pkg::*;

  localparam int NPROG           = 3;
  localparam int WATCHDOG_CYCLES = NPROG * 400;

  logic              clk;
  logic              rst;
  logic              prog_we;
  logic [5:0]        prog_addr;
  word_t             prog_data;
  reg_idx_t          dbg_addr;
  word_t             dbg_data;
  logic              dmem_req;
  dmem_req_t         dmem_pkt;
  logic              dmem_ack = 1'b0;
  word_t             dmem_rdata = 32'hdead_beef;
  logic              halted;

  word_t             prog_words [0:NPROG-1][0:63];
  int                prog_len [0:NPROG-1];
  word_t             mregs [0:31];
  logic              known [0:31];
  word_t             mmem [0:63];
  word_t             dmem [0:63];
  logic [63:0]       exp_stores [$];
  logic [15:0]       lfsr_state = 16'd46;
  int                err_regs;
  int                err_bus;
  int                err_reset;

  rv_core DUT (.*);

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // instruction encoders and stimulus helpers
  //////////////////////////////////////////////////

  function automatic word_t r_type(input int sub, input int f3, input int rd,
                                   input int rs1, input int rs2);
    return {1'b0, 1'(sub), 5'b0, 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), `RV_OP_OP};
  endfunction

  function automatic word_t i_type(input logic [6:0] opc, input int f3, input int rd,
                                   input int rs1, input int imm);
    word_t v;
    v = imm;
    return {v[11:0], 5'(rs1), 3'(f3), 5'(rd), opc};
  endfunction

  // sw rs2, imm(rs1)
  function automatic word_t s_type(input int rs1, input int rs2, input int imm);
    word_t v;
    v = imm;
    return {v[11:5], 5'(rs2), 5'(rs1), 3'b010, v[4:0], `RV_OP_STORE};
  endfunction

  function automatic word_t b_type(input int ne, input int rs1, input int rs2, input int imm);
    word_t v;
    v = imm;
    return {v[12], v[10:5], 5'(rs2), 5'(rs1), 2'b00, 1'(ne), v[4:1], v[11], `RV_OP_BRANCH};
  endfunction

  function automatic word_t u_type(input int rd, input int imm20);
    word_t v;
    v = imm20;
    return {v[19:0], 5'(rd), `RV_OP_LUI};
  endfunction

  // every word differs with the full byte address
  function automatic word_t fill_word(input int addr);
    return 32'ha5a5_0000 ^ (word_t'(addr) * 32'h0001_0003);
  endfunction

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic int rand_bits(input int n);
    int r;
    r = 0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_state = lfsr_step(lfsr_state);
      r = (r << 1) | int'(lfsr_state[0]);
    end
    return r;
  endfunction

  task automatic emit(input int p, input word_t w);
    prog_words[p][prog_len[p]] = w;
    prog_len[p]++;
  endtask

  task automatic build_programs();
    for (int p = 0; p < NPROG; p++)
      prog_len[p] = 0;
    // alu chain, back-to-back dependences, write to x0
    emit(0, i_type(`RV_OP_OPIMM, 0, 1, 0, 5));
    emit(0, i_type(`RV_OP_OPIMM, 0, 2, 1, 7));
    emit(0, r_type(0, 0, 3, 1, 2));
    emit(0, r_type(1, 0, 4, 3, 1));
    emit(0, r_type(0, 4, 5, 4, 2));
    emit(0, u_type(6, 'h12345));
    emit(0, i_type(`RV_OP_OPIMM, 6, 6, 6, 'h678));
    emit(0, r_type(0, 7, 7, 6, 3));
    emit(0, r_type(0, 6, 8, 7, 4));
    emit(0, r_type(0, 2, 9, 4, 3));
    emit(0, i_type(`RV_OP_OPIMM, 0, 10, 0, -3));
    emit(0, r_type(0, 2, 11, 10, 1));
    emit(0, i_type(`RV_OP_OPIMM, 4, 12, 10, -1));
    emit(0, i_type(`RV_OP_OPIMM, 7, 13, 6, 'hff));
    emit(0, i_type(`RV_OP_OPIMM, 0, 0, 0, 9));
    emit(0, r_type(0, 0, 14, 0, 1));
    emit(0, b_type(0, 0, 0, 0));
    // stores and loads, load-use on rs1 and on store data
    emit(1, i_type(`RV_OP_OPIMM, 0, 1, 0, 'h40));
    emit(1, i_type(`RV_OP_OPIMM, 0, 2, 0, 123));
    emit(1, s_type(1, 2, 0));
    emit(1, s_type(1, 1, 4));
    emit(1, i_type(`RV_OP_LOAD, 2, 3, 1, 0));
    emit(1, r_type(0, 0, 4, 3, 2));
    emit(1, i_type(`RV_OP_LOAD, 2, 5, 1, 4));
    emit(1, s_type(1, 5, 8));
    emit(1, i_type(`RV_OP_LOAD, 2, 6, 1, 8));
    emit(1, i_type(`RV_OP_LOAD, 2, 7, 1, 12));
    emit(1, i_type(`RV_OP_OPIMM, 0, 8, 6, 1));
    emit(1, s_type(1, 4, -4));
    emit(1, i_type(`RV_OP_LOAD, 2, 9, 1, -4));
    emit(1, r_type(0, 4, 10, 9, 7));
    emit(1, b_type(0, 0, 0, 0));
    // branches, taken and not, with a short loop
    emit(2, i_type(`RV_OP_OPIMM, 0, 1, 0, 3));
    emit(2, i_type(`RV_OP_OPIMM, 0, 2, 0, 3));
    emit(2, b_type(0, 1, 2, 12));
    emit(2, i_type(`RV_OP_OPIMM, 0, 3, 0, 111));
    emit(2, i_type(`RV_OP_OPIMM, 0, 4, 0, 222));
    emit(2, b_type(1, 1, 2, 8));
    emit(2, i_type(`RV_OP_OPIMM, 0, 5, 0, 5));
    emit(2, i_type(`RV_OP_OPIMM, 0, 6, 6, 2));
    emit(2, i_type(`RV_OP_OPIMM, 0, 1, 1, -1));
    emit(2, b_type(1, 1, 0, -8));
    emit(2, b_type(0, 1, 2, 8));
    emit(2, i_type(`RV_OP_OPIMM, 0, 7, 0, 77));
    emit(2, i_type(`RV_OP_OPIMM, 0, 8, 0, 88));
    emit(2, b_type(0, 0, 0, 0));
  endtask

  //////////////////////////////////////////////////
  // instruction-set reference model
  //////////////////////////////////////////////////

  function automatic word_t alu_ref(input logic [2:0] f3, input logic sub,
                                    input word_t a, input word_t b);
    word_t r;
    case (f3)
      3'd0:    r = sub ? a - b : a + b;
      3'd2:    r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd4:    r = a ^ b;
      3'd6:    r = a | b;
      default: r = a & b;
    endcase
    return r;
  endfunction

  // runs until a taken branch lands on itself
  function automatic void run_model(input int p);
    word_t       pc;
    word_t       ins;
    word_t       a;
    word_t       b;
    word_t       res;
    word_t       addr;
    word_t       next_pc;
    word_t       imm_i;
    word_t       imm_s;
    word_t       imm_b;
    logic        wr;
    logic        stop;
    int          steps;
    pc = '0;
    stop = 1'b0;
    steps = 0;
    while (!stop && steps < 500)
    begin
      ins = prog_words[p][pc[7:2]];
      a = mregs[ins[19:15]];
      b = mregs[ins[24:20]];
      imm_i = {{20{ins[31]}}, ins[31:20]};
      imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
      imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
      wr = 1'b0;
      res = '0;
      next_pc = pc + 32'd4;
      case (ins[6:0])
        `RV_OP_OP:
        begin
          wr = 1'b1;
          res = alu_ref(ins[14:12], ins[30], a, b);
        end
        `RV_OP_OPIMM:
        begin
          wr = 1'b1;
          res = alu_ref(ins[14:12], 1'b0, a, imm_i);
        end
        `RV_OP_LUI:
        begin
          wr = 1'b1;
          res = {ins[31:12], 12'b0};
        end
        `RV_OP_LOAD:
        begin
          wr = 1'b1;
          addr = a + imm_i;
          res = mmem[addr[7:2]];
        end
        `RV_OP_STORE:
        begin
          addr = a + imm_s;
          mmem[addr[7:2]] = b;
          exp_stores.push_back({addr, b});
        end
        default:
        begin
          if (ins[12] ? (a != b) : (a == b))
          begin
            next_pc = pc + imm_b;
            stop = (next_pc == pc);
          end
        end
      endcase
      if (wr && ins[11:7] != 5'd0)
      begin
        mregs[ins[11:7]] = res;
        known[ins[11:7]] = 1'b1;
      end
      pc = next_pc;
      steps++;
    end
  endfunction

  //////////////////////////////////////////////////
  // data memory slave and bus monitor
  //////////////////////////////////////////////////

  logic        req_seen = 1'b0;
  dmem_req_t   pkt_seen;
  logic        pending = 1'b0;
  int          delay;
  logic [63:0] exp_store;

  always @(negedge clk)
  begin
    if (req_seen && !dmem_req)
      assert (dmem_ack)
      else
      begin
        err_bus++;
        $display("t=%0t: req dropped before the memory acknowledged it", $time);
      end
    if (req_seen && dmem_req)
      assert (dmem_pkt === pkt_seen)
      else
      begin
        err_bus++;
        $display("ERROR t=%0t dmem_pkt got %h expected %h", $time, dmem_pkt, pkt_seen);
      end
    if (!req_seen && dmem_req)
      assert (!dmem_ack)
      else
      begin
        err_bus++;
        $display("t=%0t: req raised while ack was still high", $time);
      end
    req_seen = dmem_req;
    pkt_seen = dmem_pkt;
    if (dmem_req && !dmem_ack)
    begin
      // ack after 0 to 3 cycles
      if (!pending)
      begin
        pending = 1'b1;
        delay = rand_bits(2);
      end
      if (delay == 0)
      begin
        pending = 1'b0;
        dmem_ack = 1'b1;
        if (dmem_pkt.we)
        begin
          dmem[dmem_pkt.addr[7:2]] = dmem_pkt.wdata;
          assert (exp_stores.size() > 0)
          else
          begin
            err_bus++;
            $display("t=%0t: store to %h that the model never made", $time, dmem_pkt.addr);
          end
          if (exp_stores.size() > 0)
          begin
            exp_store = exp_stores.pop_front();
            assert ({dmem_pkt.addr, dmem_pkt.wdata} === exp_store)
            else
            begin
              err_bus++;
              $display("ERROR t=%0t dmem_pkt addr/wdata got %h/%h expected %h/%h", $time,
                       dmem_pkt.addr, dmem_pkt.wdata, exp_store[63:32], exp_store[31:0]);
            end
          end
        end
        else
          dmem_rdata = dmem[dmem_pkt.addr[7:2]];
      end
      else
        delay--;
    end
    else if (!dmem_req && dmem_ack)
    begin
      dmem_ack = 1'b0;
      dmem_rdata = 32'hdead_beef;
    end
  end

  //////////////////////////////////////////////////
  // sequence
  //////////////////////////////////////////////////

  // program goes in with the core in reset, then ten more reset cycles
  task automatic load_and_reset(input int p);
    rst = 1'b1;
    for (int i = 0; i < prog_len[p]; i++)
    begin
      prog_we = 1'b1;
      prog_addr = 6'(i);
      prog_data = prog_words[p][i];
      @(negedge clk);
    end
    prog_we = 1'b0;
    repeat (10) @(negedge clk);
    assert (dmem_req === 1'b0)
    else
    begin
      err_reset++;
      $display("ERROR t=%0t dmem_req got %b expected 0", $time, dmem_req);
    end
    assert (halted === 1'b0)
    else
    begin
      err_reset++;
      $display("ERROR t=%0t halted got %b expected 0", $time, halted);
    end
    assert (dbg_data === '0)
    else
    begin
      err_reset++;
      $display("ERROR t=%0t dbg_data got %h expected 00000000", $time, dbg_data);
    end
    rst = 1'b0;
  endtask

  task automatic check_registers(input int p);
    for (int i = 0; i < 32; i++)
    begin
      dbg_addr = 5'(i);
      @(negedge clk);
      if (known[i])
        assert (dbg_data === mregs[i])
        else
        begin
          err_regs++;
          $display("ERROR t=%0t dbg_data x%0d got %h expected %h (program %0d)",
                   $time, i, dbg_data, mregs[i], p);
        end
    end
  endtask

  initial
  begin
    rst = 1'b1;
    prog_we = 1'b0;
    prog_addr = '0;
    prog_data = '0;
    dbg_addr = '0;
    err_regs = 0;
    err_bus = 0;
    err_reset = 0;
    build_programs();
    for (int i = 0; i < 64; i++)
    begin
      dmem[i] = fill_word(i * 4);
      mmem[i] = fill_word(i * 4);
    end
    // registers keep their contents across resets
    for (int i = 0; i < 32; i++)
    begin
      mregs[i] = '0;
      known[i] = (i == 0);
    end
    @(negedge clk);
    for (int p = 0; p < NPROG; p++)
    begin
      run_model(p);
      load_and_reset(p);
      while (!halted)
        @(negedge clk);
      repeat (3) @(negedge clk);
      check_registers(p);
      assert (exp_stores.size() == 0)
      else
      begin
        err_bus++;
        $display("program %0d: %0d expected stores never reached the bus", p,
                 exp_stores.size());
        exp_stores.delete();
      end
    end
    $display("errors: registers %0d, bus %0d, reset %0d", err_regs, err_bus, err_reset);
    if (err_regs + err_bus + err_reset == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

  // whole run budget
  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog: run exceeded %0d cycles, halted did not rise in time",
             WATCHDOG_CYCLES);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

// ==== sim.f ====
+incdir+hw
hw/rv_pkg.sv
hw/pipe_reg.sv
hw/fetch_stage.sv
hw/regfile.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/memory_stage.sv
hw/rv_core.sv
tests/rv_core_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module rv_core_tb -f sim.f -o rv_core_sim

out="$(./obj_dir/rv_core_sim)"
echo "$out"

if echo "$out" | grep -qx "TESTBENCH PASSED"; then
  exit 0
fi
exit 1
